/* Makefile */
SRCS := $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_rtg_video
	@out=$$(./obj_dir/Vtb_rtg_video); echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

obj_dir/Vtb_rtg_video: $(SRCS) sim.f
	verilator --binary --timing --assert -f sim.f --top-module tb_rtg_video -o Vtb_rtg_video

clean:
	rm -rf obj_dir

/* sim.f */
+incdir+src
src/rtg_pkg.sv
src/rtg_cfg_if.sv
src/rtg_apb_regs.sv
src/rtg_stream_fifo.sv
src/rtg_pixel_timing.sv
src/rtg_pixel_format.sv
src/rtg_video_top.sv
testbench/rtg_asserts.sv
testbench/tb_rtg_video.sv

/* src/rtg_apb_regs.sv */
/*
 * APB3 slave holding the RTG control registers, zero wait states.
 * Writes into the CLUT window leave as a one-cycle palette write on cfg.
 * Unmapped addresses answer with pslverr in the access phase.
 */
`timescale 1ns/100ps
`include "rtg_params.svh"

module rtg_apb_regs (
	input  logic CLK_114,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`RTG_APB_AW-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	rtg_cfg_if.regs cfg
);
	localparam int aw = `RTG_APB_AW;
	localparam logic [aw-1:0] clut_base = aw'(`RTG_CLUT_BASE);

	logic [`RTG_ADDR_W-1:4] base_hi;    // Frame base, 16-word aligned
	logic sel_ctrl, sel_pixw, sel_vbend, sel_base, sel_clut;
	logic mapped, access, wr_en;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	assign sel_ctrl = paddr == `RTG_REG_CTRL;
	assign sel_pixw = paddr == `RTG_REG_PIXW;
	assign sel_vbend = paddr == `RTG_REG_VBEND;
	assign sel_base = paddr == `RTG_REG_BASE;
	assign sel_clut = paddr[aw-1:10] == clut_base[aw-1:10]; // 1 KB window, 4 bytes per entry
	assign mapped = sel_ctrl | sel_pixw | sel_vbend | sel_base | sel_clut;

	assign access = psel & penable;    // Second APB phase
	assign wr_en = access & pwrite;

	assign pready = 1'b1;              // Never stalls
	assign pslverr = access & ~mapped;

	////////////////////////////////////////
	// Register storage
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			cfg.ena <= 1'b0;
			cfg.clut_mode <= 1'b0;
			cfg.ext <= 1'b0;
			cfg.pixel_width <= '0;
			cfg.vb_end <= '0;
			base_hi <= '0;
			cfg.clut_we <= 1'b0;
		end else begin
			cfg.clut_we <= wr_en & sel_clut;           // Pulse, one cycle
			if (wr_en && sel_ctrl) begin
				cfg.ena <= pwdata[0];
				cfg.clut_mode <= pwdata[1];
				cfg.ext <= pwdata[2];
			end
			if (wr_en && sel_pixw)
				cfg.pixel_width <= pwdata[`RTG_PW_W-1:0];
			if (wr_en && sel_vbend)
				cfg.vb_end <= pwdata[`RTG_VB_W-1:0];
			if (wr_en && sel_base)
				base_hi <= pwdata[`RTG_ADDR_W-1:4];        // Low nibble dropped
		end
	end

	// Palette payload travels with the pulse
	always_ff @(posedge CLK_114) begin
		if (wr_en && sel_clut) begin
			cfg.clut_idx <= paddr[9:2];                // Entry number
			cfg.clut_rgb <= pwdata[23:0];              // R in bits 23..16
		end
	end

	assign cfg.base_addr = {base_hi, 4'b0000};

	// Read mux, CLUT is write only
	always_comb begin
		prdata = '0;
		if (sel_ctrl)
			prdata = {29'b0, cfg.ext, cfg.clut_mode, cfg.ena};
		else if (sel_pixw)
			prdata = 32'(cfg.pixel_width);
		else if (sel_vbend)
			prdata = 32'(cfg.vb_end);
		else if (sel_base)
			prdata = 32'(cfg.base_addr);
	end
endmodule

/* src/rtg_cfg_if.sv */
/*
 * Register values and CLUT writes from the APB block to the datapath.
 * The register block takes the regs side, every datapath block the dp side.
 */
`timescale 1ns/100ps
`include "rtg_params.svh"

interface rtg_cfg_if;
	logic ena;                          // RTG screen on
	logic clut_mode;                    // 8-bit CLUT instead of RGB555
	logic ext;                          // Extend active area by one clock
	logic [`RTG_PW_W-1:0] pixel_width;  // Clocks per fetch minus one
	logic [`RTG_VB_W-1:0] vb_end;       // Lines of extra vblank
	rtg_pkg::addr_t base_addr;          // Frame start, low bits zero

	logic clut_we;                      // One-cycle palette write
	rtg_pkg::clut_idx_t clut_idx;
	rtg_pkg::rgb_t clut_rgb;

	modport regs (output ena, clut_mode, ext, pixel_width, vb_end, base_addr,
		clut_we, clut_idx, clut_rgb);
	modport dp (input ena, clut_mode, ext, pixel_width, vb_end, base_addr,
		clut_we, clut_idx, clut_rgb);
endinterface

/* src/rtg_params.svh */
/*
 * Widths, burst sizing and the APB register map of the RTG display path.
 * Include this file wherever one of the macros is needed.
 */
`ifndef RTG_PARAMS_SVH
`define RTG_PARAMS_SVH

// Memory side
`define RTG_ADDR_W      25      // Word address into frame-buffer memory
`define RTG_BURST       4       // Words per memory request
`define RTG_FIFO_DEPTH  16      // Stream FIFO depth in words

// Register field widths
`define RTG_PW_W        4       // Clocks per fetch minus one
`define RTG_VB_W        7       // Extra vblank lines
`define RTG_APB_AW      12      // APB byte address width

// Register map, byte addresses
`define RTG_REG_CTRL    12'h000 // ena, clut mode, ext
`define RTG_REG_PIXW    12'h004 // Pixel width
`define RTG_REG_VBEND   12'h008 // Vblank end line count
`define RTG_REG_BASE    12'h00C // Frame base, bits 24..4
`define RTG_CLUT_BASE   12'h400 // 256 entries, one per word

`endif

/* src/rtg_pixel_format.sv */
/*
 * Turns FIFO words into output colours. Holds the 256-entry CLUT,
 * expands RGB555, and registers either the RTG colour or the native
 * chipset colour together with the pixel strobe.
 */
`timescale 1ns/100ps

module rtg_pixel_format (
	input  logic CLK_114,
	input  logic reset,
	rtg_cfg_if.dp cfg,
	input  logic fetch,
	input  logic half,
	input  logic active,
	input  rtg_pkg::word_t q,
	input  rtg_pkg::rgb_t nat,
	output rtg_pkg::rgb_t vga_rgb,
	output logic vga_pixel
);
	rtg_pkg::rgb_t clut [256];      // Palette RAM
	rtg_pkg::word_t word_r;         // Word taken on the last fetch
	rtg_pkg::clut_idx_t idx;
	rtg_pkg::rgb_t lut_rgb, hi_rgb, pix_rgb;
	logic fetch_d, half_d;

	always_ff @(posedge CLK_114) begin
		if (cfg.clut_we)
			clut[cfg.clut_idx] <= cfg.clut_rgb;
	end

	////////////////////////////////////////
	// Stage 1, capture word and strobes
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (fetch)
			word_r <= q;                // Head word before the pop
	end

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			fetch_d <= 1'b0;
			half_d <= 1'b0;
		end else begin
			fetch_d <= fetch;
			half_d <= half;
		end
	end

	// High byte first, low byte on the half strobe
	assign idx = half_d ? word_r[7:0] : word_r[15:8];
	assign lut_rgb = clut[idx];

	// RGB555, top bits replicated into the low bits
	assign hi_rgb = {word_r[14:10], word_r[14:12],
		word_r[9:5], word_r[9:7],
		word_r[4:0], word_r[4:2]};

	assign pix_rgb = cfg.clut_mode ? lut_rgb : hi_rgb;

	////////////////////////////////////////
	// Stage 2, output register
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		vga_rgb <= (cfg.ena && active) ? pix_rgb : nat; // Native when off or blank
	end

	always_ff @(posedge CLK_114) begin
		if (reset)
			vga_pixel <= 1'b0;
		else
			vga_pixel <= cfg.ena & active & (fetch_d | half_d);
	end
endmodule

/* src/rtg_pixel_timing.sv */
/*
 * Pixel pacing for the RTG screen. Extends vblank by vb_end hsync lines,
 * runs the fetch counter outside blank and derives the fetch strobe,
 * the CLUT second-half strobe and a one-cycle delayed active flag.
 */
`timescale 1ns/100ps
`include "rtg_params.svh"

module rtg_pixel_timing (
	input  logic CLK_114,
	input  logic reset,
	input  logic hblank,
	input  logic vblank,
	input  logic hsync,
	rtg_cfg_if.dp cfg,
	output logic fetch,
	output logic half,
	output logic active
);
	logic [`RTG_PW_W-1:0] ctr;      // Clocks into current fetch period
	logic [`RTG_VB_W-1:0] vb_cnt;   // Lines since vblank fell
	logic rtg_vblank, blank, blank_d;
	logic hs_d;
	logic primed;                   // A word is held for the low half
	logic at_end, at_mid;

	////////////////////////////////////////
	// Extended vertical blank
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			rtg_vblank <= 1'b1;
			vb_cnt <= '0;
			hs_d <= 1'b0;
		end else begin
			hs_d <= hsync;
			if (vblank) begin
				rtg_vblank <= 1'b1;
				vb_cnt <= '0;
			end else if (vb_cnt == cfg.vb_end) begin
				rtg_vblank <= 1'b0;
			end else if (hsync && !hs_d) begin
				vb_cnt <= vb_cnt + 1'b1;        // Rising edge of hsync
			end
		end
	end

	assign blank = rtg_vblank | hblank;

	////////////////////////////////////////
	// Fetch counter
	////////////////////////////////////////

	assign at_end = ctr == cfg.pixel_width;
	assign at_mid = ctr == (cfg.pixel_width >> 1);

	// ext lets one more fetch through on the first blank clock
	assign fetch = cfg.ena & (~blank | (~blank_d & cfg.ext)) & at_end;

	// Low byte of the word fetched last; needs pixel_width of 1 or more
	assign half = cfg.ena & cfg.clut_mode & primed & ~blank & at_mid & ~at_end;

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			ctr <= '0;
			blank_d <= 1'b1;
			active <= 1'b0;
			primed <= 1'b0;
		end else begin
			blank_d <= blank;
			active <= ~blank | (~blank_d & cfg.ext); // Lines up with fetch stage
			if (blank || fetch)
				ctr <= '0;
			else
				ctr <= ctr + 1'b1;
			if (rtg_vblank)
				primed <= 1'b0;                 // New frame, nothing held
			else if (fetch)
				primed <= 1'b1;
		end
	end
endmodule

/* src/rtg_pkg.sv */
/*
 * Shared data types of the RTG display path.
 * Modules refer to them by scoped names.
 */
`include "rtg_params.svh"

package rtg_pkg;

	////////////////////////////////////////
	// Memory side
	////////////////////////////////////////

	typedef logic [15:0] word_t;                // One frame-buffer word
	typedef logic [`RTG_ADDR_W-1:0] addr_t;     // Word address

	////////////////////////////////////////
	// Colour side
	////////////////////////////////////////

	typedef logic [7:0] chan_t;                 // One colour channel

	// Packed as r in the top byte, b in the low byte
	typedef struct packed {
		chan_t r;                               // Red
		chan_t g;                               // Green
		chan_t b;                               // Blue
	} rgb_t;

	typedef logic [7:0] clut_idx_t;             // 8-bit palette index

endpackage

/* src/rtg_stream_fifo.sv */
/*
 * Frame-buffer fetcher with a word FIFO in front of the pixel formatter.
 * Issues one burst request at a time when a whole burst fits, stepping
 * the address from the frame base. Held clear in vblank or with RTG off.
 */
`timescale 1ns/100ps
`include "rtg_params.svh"

module rtg_stream_fifo (
	input  logic CLK_114,
	input  logic reset,
	input  logic vblank,
	rtg_cfg_if.dp cfg,
	output logic mem_req,
	output rtg_pkg::addr_t mem_addr,
	input  logic mem_fill,
	input  rtg_pkg::word_t mem_rdata,
	input  logic rd,
	output rtg_pkg::word_t q,
	output logic empty
);
	localparam int aw = $clog2(`RTG_FIFO_DEPTH);
	localparam int bw = $clog2(`RTG_BURST) + 1;

	rtg_pkg::word_t buffer [`RTG_FIFO_DEPTH];   // Word storage
	logic [aw-1:0] wr_ptr, rd_ptr;
	logic [aw:0] count;                         // Words held
	logic [aw:0] room;                          // Free slots
	logic [bw-1:0] burst_left;                  // Fills still due
	logic clr, push, pop, issue;

	assign clr = reset | vblank | ~cfg.ena;     // Restart each frame
	assign empty = count == '0;
	assign pop = rd & ~empty;                   // Ignore reads on empty
	assign push = mem_fill & (burst_left != '0); // Stray fills dropped
	assign room = (aw+1)'(`RTG_FIFO_DEPTH) - count;

	// Next burst only once the last one has landed
	assign issue = ~mem_req & (burst_left == '0) & (room >= (aw+1)'(`RTG_BURST));

	////////////////////////////////////////
	// Request side
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (clr) begin
			mem_req <= 1'b0;
			burst_left <= '0;
		end else begin
			if (issue) begin
				mem_req <= 1'b1;
				burst_left <= bw'(`RTG_BURST);
			end else if (push) begin
				burst_left <= burst_left - 1'b1;
			end
			if (mem_req && mem_fill)
				mem_req <= 1'b0;                // First word acks the request
		end
	end

	// Address of the pending or next request
	always_ff @(posedge CLK_114) begin
		if (clr)
			mem_addr <= cfg.base_addr;
		else if (mem_req && mem_fill)
			mem_addr <= mem_addr + rtg_pkg::addr_t'(`RTG_BURST);
	end

	////////////////////////////////////////
	// FIFO pointers
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;            // Both or neither
			endcase
		end
	end

	always_ff @(posedge CLK_114) begin
		if (push)
			buffer[wr_ptr] <= mem_rdata;
	end

	assign q = buffer[rd_ptr];                  // Show-ahead head word
endmodule

/* src/rtg_video_top.sv */
/*
 * Top of the RTG display path: APB registers, frame-buffer stream,
 * pixel timing and formatter, all on CLK_114.
 */
`timescale 1ns/100ps
`include "rtg_params.svh"

module rtg_video_top (
	input  logic CLK_114,
	input  logic reset,
	// APB3
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`RTG_APB_AW-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// Frame-buffer memory
	output logic mem_req,
	output logic [`RTG_ADDR_W-1:0] mem_addr,
	input  logic mem_fill,
	input  logic [15:0] mem_rdata,
	// Chipset video
	input  logic hblank,
	input  logic vblank,
	input  logic hsync,
	input  logic [7:0] nat_r,
	input  logic [7:0] nat_g,
	input  logic [7:0] nat_b,
	// Display
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_pixel
);
	rtg_pkg::word_t fifo_q;         // Head of the stream FIFO
	logic fifo_empty;
	logic fetch, half, active;
	rtg_pkg::rgb_t nat, vga_rgb;

	assign nat = {nat_r, nat_g, nat_b};
	assign {vga_r, vga_g, vga_b} = vga_rgb;

	rtg_cfg_if cfg ();

	rtg_apb_regs u_regs (.CLK_114, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .cfg(cfg.regs));

	rtg_stream_fifo u_stream (.CLK_114, .reset, .vblank, .cfg(cfg.dp),
		.mem_req, .mem_addr, .mem_fill, .mem_rdata,
		.rd(fetch), .q(fifo_q), .empty(fifo_empty));

	rtg_pixel_timing u_timing (.CLK_114, .reset, .hblank, .vblank, .hsync,
		.cfg(cfg.dp), .fetch, .half, .active);

	rtg_pixel_format u_format (.CLK_114, .reset, .cfg(cfg.dp), .fetch, .half, .active,
		.q(fifo_q), .nat, .vga_rgb, .vga_pixel);
endmodule

/* testbench/rtg_asserts.sv */
/*
 * Concurrent checks on the RTG top level, bound into every rtg_video_top.
 * Covers the memory request handshake, FIFO pops and APB errors.
 */
`timescale 1ns/100ps
`include "rtg_params.svh"

module rtg_asserts (
	input logic CLK_114,
	input logic reset,
	input logic vblank,
	input logic ena,
	input logic mem_req,
	input logic mem_fill,
	input logic fetch,
	input logic fifo_empty,
	input logic pslverr,
	input logic penable,
	input logic [`RTG_APB_AW-1:0] paddr
);
	int err_cnt = 0;                // Failed assertion count
	logic mapped;

	// Register map plus the 256-entry palette window
	assign mapped = paddr inside {`RTG_REG_CTRL, `RTG_REG_PIXW, `RTG_REG_VBEND, `RTG_REG_BASE}
		|| (paddr >= `RTG_CLUT_BASE && 13'(paddr) < 13'(`RTG_CLUT_BASE) + 13'h400);

	// Request holds until the first word, fetcher clear aside
	a_req_hold: assert property (@(posedge CLK_114) disable iff (reset || vblank || !ena)
		mem_req && !mem_fill |=> mem_req)
		else begin
			$error("mem_req dropped before mem_fill");
			err_cnt++;
		end

	a_no_pop_empty: assert property (@(posedge CLK_114) disable iff (reset)
		!(fetch && fifo_empty))
		else begin
			$error("FIFO popped while empty");
			err_cnt++;
		end

	a_slverr_phase: assert property (@(posedge CLK_114) disable iff (reset)
		pslverr |-> penable && !mapped)
		else begin
			$error("pslverr outside the access phase or on a mapped address");
			err_cnt++;
		end
endmodule

bind rtg_video_top rtg_asserts u_asserts (.CLK_114, .reset, .vblank, .ena(cfg.ena),
	.mem_req, .mem_fill, .fetch, .fifo_empty, .pslverr, .penable, .paddr);

/* testbench/tb_rtg_video.sv */
/*
 * Testbench for the RTG display path. Checks APB registers, native passthrough,
 * then RGB555 and CLUT frames from a random memory, against a model here.
 */
`timescale 1ns/100ps
`include "rtg_params.svh"

module tb_rtg_video;
	localparam int hb_len = 40;                 // Clocks of hblank per line
	localparam int frame_max = 9 * (hb_len + 84); // Nine lines of the longest kind
	localparam int n_frames = 5;

	logic CLK_114, reset;
	logic psel, penable, pwrite, pready, pslverr;
	logic [`RTG_APB_AW-1:0] paddr;
	logic [31:0] pwdata, prdata;
	logic mem_req, mem_fill;
	rtg_pkg::addr_t mem_addr;
	rtg_pkg::word_t mem_rdata;
	logic hblank, vblank, hsync, vga_pixel;
	rtg_pkg::rgb_t nat, vga;

	rtg_pkg::word_t mem [4096];                 // Frame-buffer model
	rtg_pkg::rgb_t clut_m [256];                // Palette as written
	logic [15:0] lfsr, mem_lfsr;                // Stimulus and memory streams
	logic cur_clut, nat_check, pix_check;
	logic [3:0] cur_pw;
	logic [6:0] cur_vbend;
	rtg_pkg::addr_t cur_base, exp_addr;
	int widx, hs_cnt, frame_pix;
	logic half_sel, hs_prev;
	rtg_pkg::rgb_t nat_prev;

	rtg_video_top UUT (.CLK_114, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .mem_req, .mem_addr, .mem_fill, .mem_rdata,
		.hblank, .vblank, .hsync, .nat_r(nat.r), .nat_g(nat.g), .nat_b(nat.b),
		.vga_r(vga.r), .vga_g(vga.g), .vga_b(vga.b), .vga_pixel);

	initial begin
		CLK_114 = 1'b0;
		forever #5 CLK_114 = ~CLK_114;
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rnd(inout logic [15:0] s, input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
			v = {v[30:0], s[0]};
		end
		return v;
	endfunction

	// One RGB555 channel to eight bits, top bits repeated below
	function automatic rtg_pkg::chan_t widen(logic [4:0] c);
		return {c, 3'b000} | rtg_pkg::chan_t'(c >> 2);
	endfunction

	function automatic rtg_pkg::rgb_t expand(rtg_pkg::word_t w);
		rtg_pkg::rgb_t e;
		e.r = widen(w[14:10]);
		e.g = widen(w[9:5]);
		e.b = widen(w[4:0]);
		return e;
	endfunction

	////////////////////////////////////////
	// Failure reporting and compares
	////////////////////////////////////////

	task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
		$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic fail_msg(string msg);
		$display("%s at t=%0t", msg, $time);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_rgb(string name, rtg_pkg::rgb_t got, rtg_pkg::rgb_t exp);
		if (got !== exp)
			fail_value(name, 32'(got), 32'(exp));
	endtask

	task automatic check_addr(string name, rtg_pkg::addr_t got, rtg_pkg::addr_t exp);
		if (got !== exp)
			fail_value(name, 32'(got), 32'(exp));
	endtask

	task automatic check_data(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
			fail_value(name, got, exp);
	endtask

	////////////////////////////////////////
	// APB and chipset drivers
	////////////////////////////////////////

	task automatic apb_access(logic wr, logic [11:0] a, logic [31:0] d,
		output logic [31:0] rdata, output logic err);
		@(posedge CLK_114);
		psel <= 1'b1;                           // Setup phase
		pwrite <= wr;
		paddr <= a;
		pwdata <= d;
		@(posedge CLK_114);
		penable <= 1'b1;                        // Access phase
		@(posedge CLK_114);
		rdata = prdata;
		err = pslverr;
		check_data("pready", {31'b0, pready}, 32'd1); // Zero wait states
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(logic [11:0] a, logic [31:0] d);
		logic [31:0] r;
		logic e;
		apb_access(1'b1, a, d, r, e);
		check_data("pslverr", {31'b0, e}, 32'd0);
	endtask

	task automatic reg_check(logic [11:0] a, logic [31:0] d, logic [31:0] mask);
		logic [31:0] r;
		logic e;
		apb_write(a, d);
		apb_access(1'b0, a, 32'd0, r, e);
		check_data("prdata", r, d & mask);
		check_data("pslverr", {31'b0, e}, 32'd0);
	endtask

	// One line: hblank with hsync, then the active part
	task automatic drive_line(logic vb, int act_len);
		for (int c = 0; c < hb_len + act_len; c++) begin
			@(posedge CLK_114);
			hblank <= c < hb_len;
			hsync <= c >= 4 && c < 8;
			if (c == 10)
				vblank <= vb;                   // Moves only inside hblank
			nat <= 24'(rnd(lfsr, 24));
		end
	endtask

	task automatic run_frame();
		int act_len;
		act_len = (cur_pw + 1) * (4 + rnd(lfsr, 2));
		frame_pix = 0;
		drive_line(1'b1, 0);                    // Two vblank lines
		drive_line(1'b1, 0);
		for (int l = 0; l < 6; l++)
			drive_line(1'b0, act_len);
		drive_line(1'b1, 0);                    // Into next vblank
	endtask

	////////////////////////////////////////
	// Memory model
	////////////////////////////////////////

	int left, wait_cnt;
	logic busy;
	rtg_pkg::addr_t burst_addr;

	always @(posedge CLK_114) begin
		if (reset || vblank) begin
			busy = 1'b0;
			mem_fill <= 1'b0;
			exp_addr = cur_base;                // Each frame restarts here
		end else if (!busy) begin
			mem_fill <= 1'b0;
			if (mem_req) begin
				check_addr("mem_addr", mem_addr, exp_addr);
				exp_addr = exp_addr + rtg_pkg::addr_t'(`RTG_BURST);
				burst_addr = mem_addr;
				left = `RTG_BURST;
				wait_cnt = rnd(mem_lfsr, 2);    // Latency 0 to 3
				busy = 1'b1;
			end
		end else if (wait_cnt > 0) begin
			wait_cnt--;
			mem_fill <= 1'b0;
		end else begin
			mem_fill <= 1'b1;
			mem_rdata <= mem[burst_addr[11:0]];
			burst_addr++;
			left--;
			wait_cnt = rnd(mem_lfsr, 1);        // Gap before next word
			if (left == 0)
				busy = 1'b0;
		end
	end

	////////////////////////////////////////
	// Output checker
	////////////////////////////////////////

	always @(posedge CLK_114) begin
		if (!reset) begin
			if (nat_check) begin
				check_rgb("vga_rgb", vga, nat_prev);
				if (vga_pixel)
					fail_msg("vga_pixel went high while RTG was off");
			end
			if (vga_pixel && pix_check) begin
				if (vblank || hs_cnt < int'(cur_vbend))
					fail_msg("vga_pixel inside the extended vertical blank");
				if (cur_clut) begin
					check_rgb("vga_rgb", vga, clut_m[half_sel ?
						mem[(cur_base + widx) % 4096][7:0] :
						mem[(cur_base + widx) % 4096][15:8]]);
					if (half_sel)
						widx++;
					half_sel = ~half_sel;
				end else begin
					check_rgb("vga_rgb", vga, expand(mem[(cur_base + widx) % 4096]));
					widx++;
				end
				frame_pix++;
			end
			if (vblank) begin
				hs_cnt = 0;
				widx = 0;
				half_sel = 1'b0;
			end else if (hsync && !hs_prev) begin
				hs_cnt++;                       // Lines since vblank fell
			end
		end
		hs_prev = hsync;
		nat_prev = nat;
	end

	always @(UUT.u_asserts.err_cnt) begin
		if (UUT.u_asserts.err_cnt != 0)
			fail_msg("A concurrent assertion in rtg_asserts failed");
	end

	initial begin
		#((n_frames * frame_max * 2 + 3000) * 10);
		$display("Watchdog expired, the test did not finish in time");
		$display("TEST FAILED");
		$fatal(1);
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic e;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		mem_fill = 1'b0;
		mem_rdata = '0;
		hblank = 1'b1;
		vblank = 1'b1;
		hsync = 1'b0;
		nat = '0;
		lfsr = 16'd58434;
		mem_lfsr = 16'd58434;
		nat_check = 1'b0;
		pix_check = 1'b0;
		cur_base = '0;
		cur_clut = 1'b0;
		cur_pw = '0;
		cur_vbend = '0;
		for (int i = 0; i < 4096; i++)
			mem[i] = 16'(rnd(lfsr, 16));
		repeat (10) @(posedge CLK_114);
		reset <= 1'b0;

		// Register readback, CLUT window, unmapped address
		reg_check(`RTG_REG_CTRL, rnd(lfsr, 32), 32'h7);
		reg_check(`RTG_REG_PIXW, rnd(lfsr, 32), 32'hf);
		reg_check(`RTG_REG_VBEND, rnd(lfsr, 32), 32'h7f);
		reg_check(`RTG_REG_BASE, rnd(lfsr, 32), 32'h01ff_fff0);
		for (int i = 0; i < 256; i++) begin
			clut_m[i] = 24'(rnd(lfsr, 24));
			apb_write(`RTG_CLUT_BASE + 12'(i * 4), 32'(clut_m[i]));
		end
		apb_access(1'b0, `RTG_CLUT_BASE + 12'h020, 32'd0, r, e);
		check_data("prdata", r, 32'd0);         // Palette is write only
		apb_access(1'b0, 12'h010, 32'd0, r, e);
		check_data("pslverr", {31'b0, e}, 32'd1);

		// Native passthrough with RTG off
		apb_write(`RTG_REG_CTRL, 32'd0);
		nat_check = 1'b1;
		cur_pw = 4'd7;
		run_frame();
		nat_check = 1'b0;

		// RTG frames, RGB555 and CLUT in turn
		for (int f = 0; f < n_frames - 1; f++) begin
			cur_clut = f[0];
			cur_pw = 4'(4 + rnd(lfsr, 3));
			cur_vbend = 7'(rnd(lfsr, 2));
			cur_base = rtg_pkg::addr_t'(rnd(lfsr, 8) << 4);
			apb_write(`RTG_REG_PIXW, 32'(cur_pw));
			apb_write(`RTG_REG_VBEND, 32'(cur_vbend));
			apb_write(`RTG_REG_BASE, 32'(cur_base));
			apb_write(`RTG_REG_CTRL, {30'b0, cur_clut, 1'b1});
			pix_check = 1'b1;
			run_frame();
			if (frame_pix == 0)
				fail_msg("No RTG pixels came out during the frame");
		end

		if (UUT.u_asserts.err_cnt == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			fail_msg("A concurrent assertion in rtg_asserts failed");
		end
	end
endmodule
